// File: list.f
verilog/tracker_pkg.sv
verilog/frame_capture.sv
verilog/mean_divider.sv
verilog/centroid_accum.sv
verilog/aim_control.sv
verilog/servo_pwm.sv
verilog/tracker_top.sv
verification/tb_clock.sv
verification/tracker_tb.sv

// File: run.sh
#!/bin/sh
# Build the tracker testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tracker_tb -f list.f &&
    ./obj_dir/Vtracker_tb | tee /dev/stderr | grep -x "TEST OK" > /dev/null &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

// File: verification/tb_clock.sv
/*
 * Testbench clock and reset
 *   free running pixel clock
 *   active low reset held for a few cycles
 */
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Released just after a rising edge
    initial
    begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/tracker_tb.sv
/*
 * Testbench of the turret tracker
 *   frame table played in a loop, LFSR pixel noise
 *   aim point, fire and servo pulse width checks
 *   cycle limit against a hung run
 */
`default_nettype none

module tracker_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IMG_W          = 16;
    localparam int IMG_H          = 12;
    localparam int PWM_PERIOD     = 256;
    localparam int PULSE_MIN      = 16;
    localparam int PULSE_STEP     = 4;
    localparam int LINE_GAP       = 4;
    localparam int V_BLANK        = 60;
    localparam int RESET_CYCLES   = 4;
    localparam int FRAME_CYCLES   = IMG_H * (IMG_W + LINE_GAP) + V_BLANK;
    // Two axes, each up to one period of waiting plus one pulse
    localparam int MEASURE_CYCLES = 2 * 2 * PWM_PERIOD;
    localparam int NUM_ROWS       = 16;

    typedef struct {
        int obj;
        int x0, x1;
        int y0, y1;
        int exp_x, exp_y, exp_fire;
        int measure;
    } frame_row_t;

    logic        clk;
    logic        arst_n;
    logic [11:0] D5M_D;
    logic        D5M_FVAL;
    logic        D5M_LVAL;
    logic        pan_pwm;
    logic        tilt_pwm;
    logic        fire;
    logic [9:0]  aim_x;
    logic [8:0]  aim_y;

    frame_row_t  rows [NUM_ROWS];
    logic [31:0] lfsr_state;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          timeout_limit = 0;
    int          frame_idx = -1;

    tb_clock #(
        .HALF_PERIOD  (100),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    tracker_top #(
        .IMG_W       (IMG_W),
        .IMG_H       (IMG_H),
        .LOCK_FRAMES (3),
        .LOST_FRAMES (2),
        .PWM_PERIOD  (PWM_PERIOD),
        .PULSE_MIN   (PULSE_MIN),
        .PULSE_STEP  (PULSE_STEP)
    ) uut (
        .D5M_PIXLCLK (clk),
        .arst_n      (arst_n),
        .D5M_D       (D5M_D),
        .D5M_FVAL    (D5M_FVAL),
        .D5M_LVAL    (D5M_LVAL),
        .pan_pwm     (pan_pwm),
        .tilt_pwm    (tilt_pwm),
        .fire        (fire),
        .aim_x       (aim_x),
        .aim_y       (aim_y)
    );

    // ====================
    // Helpers
    // ====================
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'h8020_0003;
        return state >> 1;
    endfunction

    task automatic noise_pixel(output logic [11:0] px);
        for (int i = 0; i < 12; i++)
        begin
            px = {px[10:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("error: %s is 0x%0h, expected 0x%0h (frame %0d)",
                     name, actual, expected, frame_idx);
        end
    endtask

    task automatic drive_bus(input logic fval, input logic lval, input logic [11:0] data);
        @(posedge clk);
        #10;
        D5M_FVAL = fval;
        D5M_LVAL = lval;
        D5M_D    = data;
    endtask

    // Top bit decides object or background against the 2048 threshold
    task automatic play_frame(input frame_row_t row);
        logic [11:0] px;
        logic        in_box;
        for (int y = 0; y < IMG_H; y++)
        begin
            for (int x = 0; x < IMG_W; x++)
            begin
                noise_pixel(px);
                in_box = row.obj != 0 && x >= row.x0 && x <= row.x1
                         && y >= row.y0 && y <= row.y1;
                px[11] = in_box;
                drive_bus(1'b1, 1'b1, px);
            end
            for (int g = 0; g < LINE_GAP; g++)
                drive_bus(1'b1, 1'b0, 12'h000);
        end
        for (int b = 0; b < V_BLANK; b++)
            drive_bus(1'b0, 1'b0, 12'h000);
    endtask

    function automatic logic pwm_level(input int axis);
        return (axis == 0) ? pan_pwm : tilt_pwm;
    endfunction

    // High time of the first period that starts after the call
    task automatic measure_high(input int axis, output int high_cycles);
        logic prev;
        logic cur;
        int   rises;
        rises = 0;
        prev  = pwm_level(axis);
        while (rises < 1)
        begin
            @(negedge clk);
            cur = pwm_level(axis);
            if (cur && !prev)
                rises++;
            prev = cur;
        end
        high_cycles = 0;
        while (pwm_level(axis))
        begin
            high_cycles++;
            @(negedge clk);
        end
    endtask

    // ====================
    // Cycle limit
    // ====================
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit != 0 && cycle_count >= timeout_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ====================
    // Main sequence
    // ====================
    initial
    begin
        int total;
        int width;
        D5M_D      = 12'h000;
        D5M_FVAL   = 1'b0;
        D5M_LVAL   = 1'b0;
        lfsr_state = 32'he70fba8e;

        // obj, x0, x1, y0, y1, aim_x, aim_y, fire, measure servos
        rows = '{
            '{0,  0,  0,  0,  0,  8,  6, 0, 1},
            '{0,  0,  0,  0,  0,  8,  6, 0, 0},
            '{1,  2,  5,  3,  6,  3,  4, 0, 0},
            '{1,  3,  6,  3,  6,  4,  4, 0, 0},
            '{1,  4,  7,  4,  7,  5,  5, 1, 0},
            '{1,  6,  9,  5,  8,  7,  6, 1, 0},
            '{1, 10, 13,  6,  9, 11,  7, 1, 1},
            '{0,  0,  0,  0,  0, 11,  7, 0, 0},
            '{1,  9, 12,  6,  9, 10,  7, 0, 0},
            '{0,  0,  0,  0,  0, 10,  7, 0, 0},
            '{0,  0,  0,  0,  0,  8,  6, 0, 0},
            '{0,  0,  0,  0,  0,  8,  6, 0, 0},
            '{1, 12, 15,  8, 11, 13,  9, 0, 0},
            '{1, 12, 15,  8, 11, 13,  9, 0, 0},
            '{1,  0, 15,  0, 11,  7,  5, 1, 1},
            '{1, 15, 15, 11, 11, 15, 11, 1, 1}
        };

        total = RESET_CYCLES;
        foreach (rows[i])
        begin
            total += FRAME_CYCLES;
            if (rows[i].measure != 0)
                total += MEASURE_CYCLES;
        end
        timeout_limit = total * 3 / 2;

        // Reset values before the first PWM period begins
        @(posedge arst_n);
        #1;
        check_value("fire", 32'(fire), 0);
        check_value("aim_x", 32'(aim_x), IMG_W / 2);
        check_value("aim_y", 32'(aim_y), IMG_H / 2);
        check_value("pan_pwm", 32'(pan_pwm), 0);
        check_value("tilt_pwm", 32'(tilt_pwm), 0);

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            frame_idx = r;
            play_frame(rows[r]);
            check_value("aim_x", 32'(aim_x), rows[r].exp_x);
            check_value("aim_y", 32'(aim_y), rows[r].exp_y);
            check_value("fire", 32'(fire), rows[r].exp_fire);
            if (rows[r].measure != 0)
            begin
                measure_high(0, width);
                check_value("pan_pwm high time", width, PULSE_MIN + PULSE_STEP * rows[r].exp_x);
                measure_high(1, width);
                check_value("tilt_pwm high time", width, PULSE_MIN + PULSE_STEP * rows[r].exp_y);
            end
        end

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/aim_control.sv
/*
 * Aiming control
 *   search, track and fire states driven by per-frame results
 *   hit and miss counters
 *   aim point register and fire output
 */
`default_nettype none

module aim_control #(
    parameter int LOCK_FRAMES = 3,
    parameter int LOST_FRAMES = 2,
    parameter int IMG_W       = 640,
    parameter int IMG_H       = 480
) (
    input  logic                  D5M_PIXLCLK,
    input  logic                  arst_n,
    input  logic                  result_valid,
    input  logic                  found,
    input  tracker_pkg::coord_x_t mean_x,
    input  tracker_pkg::coord_y_t mean_y,
    output tracker_pkg::coord_x_t aim_x,
    output tracker_pkg::coord_y_t aim_y,
    output logic                  fire
);
    import tracker_pkg::*;

    localparam int HIT_W  = $clog2(LOCK_FRAMES + 1);
    localparam int MISS_W = $clog2(LOST_FRAMES + 1);
    localparam coord_x_t CENTRE_X = coord_x_t'(IMG_W / 2);
    localparam coord_y_t CENTRE_Y = coord_y_t'(IMG_H / 2);

    aim_state_t        state;
    logic [HIT_W-1:0]  hit_cnt;
    logic [MISS_W-1:0] miss_cnt;

    // ====================
    // Control FSM
    // ====================
    always_ff @(posedge D5M_PIXLCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= SEARCH;
            hit_cnt  <= '0;
            miss_cnt <= '0;
            aim_x    <= CENTRE_X;
            aim_y    <= CENTRE_Y;
            fire     <= 1'b0;
        end
        else if (result_valid && found)
        begin
            aim_x    <= mean_x;
            aim_y    <= mean_y;
            miss_cnt <= '0;
            // Hit count saturates once locked
            if (hit_cnt != HIT_W'(LOCK_FRAMES))
                hit_cnt <= hit_cnt + 1'b1;
            case (state)
                SEARCH:
                begin
                    state <= TRACK;
                end
                TRACK:
                begin
                    if (hit_cnt + 1 >= LOCK_FRAMES)
                    begin
                        state <= FIRE;
                        fire  <= 1'b1;
                    end
                end
                default:
                begin
                end
            endcase
        end
        else if (result_valid)
        begin
            case (state)
                TRACK:
                begin
                    hit_cnt <= '0;
                    if (miss_cnt + 1 >= LOST_FRAMES)
                    begin
                        state    <= SEARCH;
                        miss_cnt <= '0;
                        aim_x    <= CENTRE_X;
                        aim_y    <= CENTRE_Y;
                    end
                    else
                    begin
                        miss_cnt <= miss_cnt + 1'b1;
                    end
                end
                FIRE:
                begin
                    state    <= TRACK;
                    fire     <= 1'b0;
                    hit_cnt  <= '0;
                    miss_cnt <= MISS_W'(1);
                end
                default:
                begin
                end
            endcase
        end
    end

    // ====================
    // Checks
    // ====================
    a_fire_state: assert property (@(posedge D5M_PIXLCLK) disable iff (!arst_n)
        fire == (state == FIRE))
        else $error("fire output disagrees with FSM state");

endmodule

`default_nettype wire

// File: verilog/centroid_accum.sv
/*
 * Object centroid per frame
 *   brightness threshold on the raw pixel
 *   column sum, row sum and pixel count
 *   column and row dividers started at frame end
 *   result strobe with found flag and mean coordinates
 */
`default_nettype none

module centroid_accum #(
    parameter int THRESHOLD = 2048,
    parameter int IMG_W     = 640,
    parameter int IMG_H     = 480
) (
    input  logic                  D5M_PIXLCLK,
    input  logic                  arst_n,
    input  tracker_pkg::pixel_t   pixel,
    input  tracker_pkg::coord_x_t pix_x,
    input  tracker_pkg::coord_y_t pix_y,
    input  logic                  pix_valid,
    input  logic                  frame_end,
    output logic                  result_valid,
    output logic                  found,
    output tracker_pkg::coord_x_t mean_x,
    output tracker_pkg::coord_y_t mean_y
);
    import tracker_pkg::*;

    localparam pixel_t THR = pixel_t'(THRESHOLD);

    sum_t   sum_x;
    sum_t   sum_y;
    count_t obj_cnt;
    logic   obj_pix;
    logic   empty_frame;
    logic   div_start;
    sum_t   quot_x;
    sum_t   quot_y;
    logic   done_x;
    logic   done_y;

    assign obj_pix     = pix_valid && (pixel >= THR);
    assign empty_frame = frame_end && (obj_cnt == '0);
    assign div_start   = frame_end && (obj_cnt != '0);

    // ====================
    // Accumulation
    // ====================
    // Cleared as the dividers take their operands
    always_ff @(posedge D5M_PIXLCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sum_x   <= '0;
            sum_y   <= '0;
            obj_cnt <= '0;
        end
        else if (frame_end)
        begin
            sum_x   <= '0;
            sum_y   <= '0;
            obj_cnt <= '0;
        end
        else if (obj_pix)
        begin
            sum_x   <= sum_x + sum_t'(pix_x);
            sum_y   <= sum_y + sum_t'(pix_y);
            obj_cnt <= obj_cnt + 1'b1;
        end
    end

    mean_divider div_x (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .arst_n      (arst_n),
        .start       (div_start),
        .dividend    (sum_x),
        .divisor     (obj_cnt),
        .quotient    (quot_x),
        .done        (done_x)
    );

    mean_divider div_y (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .arst_n      (arst_n),
        .start       (div_start),
        .dividend    (sum_y),
        .divisor     (obj_cnt),
        .quotient    (quot_y),
        .done        (done_y)
    );

    // ====================
    // Result
    // ====================
    always_ff @(posedge D5M_PIXLCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            result_valid <= 1'b0;
            found        <= 1'b0;
        end
        else
        begin
            result_valid <= empty_frame || (done_x && done_y);
            if (empty_frame)
                found <= 1'b0;
            else if (done_x && done_y)
                found <= 1'b1;
        end
    end

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (done_x && done_y)
        begin
            mean_x <= coord_x_t'(quot_x);
            mean_y <= coord_y_t'(quot_y);
        end
    end

    a_mean_range: assert property (@(posedge D5M_PIXLCLK) disable iff (!arst_n)
        result_valid && found |-> mean_x < IMG_W && mean_y < IMG_H)
        else $error("centroid outside the image");

endmodule

`default_nettype wire

// File: verilog/frame_capture.sv
/*
 * Camera front end
 *   registers the D5M pixel bus and its valid levels
 *   column and row counters
 *   one-cycle frame end pulse
 */
`default_nettype none

module frame_capture #(
    parameter int IMG_W = 640,
    parameter int IMG_H = 480
) (
    input  logic                  D5M_PIXLCLK,
    input  logic                  arst_n,
    input  tracker_pkg::pixel_t   D5M_D,
    input  logic                  D5M_FVAL,
    input  logic                  D5M_LVAL,
    output tracker_pkg::pixel_t   pixel,
    output tracker_pkg::coord_x_t pix_x,
    output tracker_pkg::coord_y_t pix_y,
    output logic                  pix_valid,
    output logic                  frame_end
);

    logic fval_r;
    logic lval_r;
    logic fval_d;

    assign pix_valid = fval_r & lval_r;
    assign frame_end = fval_d & ~fval_r;

    always_ff @(posedge D5M_PIXLCLK)
    begin
        pixel <= D5M_D;
    end

    always_ff @(posedge D5M_PIXLCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            fval_r <= 1'b0;
            lval_r <= 1'b0;
            fval_d <= 1'b0;
            pix_x  <= '0;
            pix_y  <= '0;
        end
        else
        begin
            fval_r <= D5M_FVAL;
            lval_r <= D5M_LVAL;
            fval_d <= fval_r;

            // Column restarts in every gap between lines
            if (pix_valid)
                pix_x <= pix_x + 1'b1;
            else
                pix_x <= '0;

            // A nonzero column outside a line marks the line just ended
            if (!fval_r)
                pix_y <= '0;
            else if (!pix_valid && pix_x != '0)
                pix_y <= pix_y + 1'b1;
        end
    end

    // ====================
    // Checks
    // ====================
    a_col_range: assert property (@(posedge D5M_PIXLCLK) disable iff (!arst_n)
        pix_valid |-> pix_x < IMG_W)
        else $error("column count past image width");

    a_row_range: assert property (@(posedge D5M_PIXLCLK) disable iff (!arst_n)
        pix_valid |-> pix_y < IMG_H)
        else $error("row count past image height");

endmodule

`default_nettype wire

// File: verilog/mean_divider.sv
/*
 * Sequential restoring divider
 *   one quotient bit per clock, first bit on the start edge
 *   done pulse with the final quotient
 */
`default_nettype none

module mean_divider (
    input  logic                D5M_PIXLCLK,
    input  logic                arst_n,
    input  logic                start,
    input  tracker_pkg::sum_t   dividend,
    input  tracker_pkg::count_t divisor,
    output tracker_pkg::sum_t   quotient,
    output logic                done
);
    import tracker_pkg::*;

    localparam int Q_W   = $bits(sum_t);
    localparam int D_W   = $bits(count_t);
    localparam int CNT_W = $clog2(Q_W);

    logic             busy;
    logic [CNT_W-1:0] step_cnt;
    count_t           rem;
    count_t           div_r;
    count_t           src_rem;
    count_t           src_div;
    sum_t             src_q;
    logic [D_W:0]     shifted;
    logic             fits;
    count_t           next_rem;
    sum_t             next_q;

    // ====================
    // Datapath
    // ====================
    // On start the step works directly on the new operands
    always_comb
    begin
        src_rem  = busy ? rem : '0;
        src_q    = busy ? quotient : dividend;
        src_div  = busy ? div_r : divisor;
        shifted  = {src_rem, src_q[Q_W-1]};
        fits     = (shifted >= {1'b0, src_div});
        next_rem = fits ? count_t'(shifted - {1'b0, src_div}) : count_t'(shifted);
        next_q   = {src_q[Q_W-2:0], fits};
    end

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (start || busy)
        begin
            rem      <= next_rem;
            quotient <= next_q;
        end
        if (start)
            div_r <= divisor;
    end

    // ====================
    // Control
    // ====================
    // Remaining Q_W-1 bits follow with done on the last one
    always_ff @(posedge D5M_PIXLCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy     <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                busy     <= 1'b1;
                step_cnt <= CNT_W'(Q_W - 2);
            end
            else if (busy)
            begin
                if (step_cnt == '0)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
                else
                begin
                    step_cnt <= step_cnt - 1'b1;
                end
            end
        end
    end

    a_start_idle: assert property (@(posedge D5M_PIXLCLK) disable iff (!arst_n)
        start |-> !busy)
        else $error("divider started while busy");

endmodule

`default_nettype wire

// File: verilog/servo_pwm.sv
/*
 * Servo PWM for one axis
 *   linear coordinate to pulse width mapping
 *   width latched at each period start
 */
`default_nettype none

module servo_pwm #(
    parameter int COORD_W    = 10,
    parameter int PWM_PERIOD = 60000,
    parameter int PULSE_MIN  = 15000,
    parameter int PULSE_STEP = 60
) (
    input  logic               D5M_PIXLCLK,
    input  logic               arst_n,
    input  logic [COORD_W-1:0] coord,
    output logic               pwm
);
    import tracker_pkg::*;

    pulse_t      period_cnt;
    pulse_t      width;
    logic        period_end;
    logic [31:0] target;

    assign period_end = (period_cnt == pulse_t'(PWM_PERIOD - 1));
    assign target     = 32'(PULSE_MIN) + 32'(coord) * 32'(PULSE_STEP);

    // Counter leaves reset on a period boundary
    always_ff @(posedge D5M_PIXLCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            period_cnt <= pulse_t'(PWM_PERIOD - 1);
            width      <= '0;
        end
        else if (period_end)
        begin
            period_cnt <= '0;
            width      <= pulse_t'(target);
        end
        else
        begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    assign pwm = (period_cnt < width);

    a_width_fits: assert property (@(posedge D5M_PIXLCLK) disable iff (!arst_n)
        period_end |-> target < PWM_PERIOD)
        else $error("servo pulse longer than PWM period");

endmodule

`default_nettype wire

// File: verilog/tracker_pkg.sv
/*
 * Shared definitions of the turret tracker
 *   vector types for pixels, coordinates, sums, counts and pulse widths
 *   aiming state encoding
 *   default image, detection, control and servo constants
 */
`default_nettype none

package tracker_pkg;

    // ====================
    // Vector types
    // ====================
    typedef logic [11:0] pixel_t;
    typedef logic [9:0]  coord_x_t;
    typedef logic [8:0]  coord_y_t;
    typedef logic [27:0] sum_t;
    typedef logic [18:0] count_t;
    typedef logic [15:0] pulse_t;

    typedef enum logic [1:0]
    {
        SEARCH,
        TRACK,
        FIRE
    } aim_state_t;

    // ====================
    // Defaults
    // ====================
    localparam int DEFAULT_IMG_W       = 640;
    localparam int DEFAULT_IMG_H       = 480;
    localparam int DEFAULT_THRESHOLD   = 2048;
    localparam int DEFAULT_LOCK_FRAMES = 3;
    localparam int DEFAULT_LOST_FRAMES = 2;

    // Servo timing in pixel clock cycles
    localparam int DEFAULT_PWM_PERIOD  = 60000;
    localparam int DEFAULT_PULSE_MIN   = 15000;
    localparam int DEFAULT_PULSE_STEP  = 60;

endpackage

`default_nettype wire

// File: verilog/tracker_top.sv
/*
 * Turret vision and aiming top level
 *   camera capture, centroid, aiming control
 *   pan and tilt servo PWM
 */
`default_nettype none

module tracker_top #(
    parameter int IMG_W       = tracker_pkg::DEFAULT_IMG_W,
    parameter int IMG_H       = tracker_pkg::DEFAULT_IMG_H,
    parameter int THRESHOLD   = tracker_pkg::DEFAULT_THRESHOLD,
    parameter int LOCK_FRAMES = tracker_pkg::DEFAULT_LOCK_FRAMES,
    parameter int LOST_FRAMES = tracker_pkg::DEFAULT_LOST_FRAMES,
    parameter int PWM_PERIOD  = tracker_pkg::DEFAULT_PWM_PERIOD,
    parameter int PULSE_MIN   = tracker_pkg::DEFAULT_PULSE_MIN,
    parameter int PULSE_STEP  = tracker_pkg::DEFAULT_PULSE_STEP
) (
    input  logic                  D5M_PIXLCLK,
    input  logic                  arst_n,
    input  tracker_pkg::pixel_t   D5M_D,
    input  logic                  D5M_FVAL,
    input  logic                  D5M_LVAL,
    output logic                  pan_pwm,
    output logic                  tilt_pwm,
    output logic                  fire,
    output tracker_pkg::coord_x_t aim_x,
    output tracker_pkg::coord_y_t aim_y
);
    import tracker_pkg::*;

    pixel_t   pixel;
    coord_x_t pix_x;
    coord_y_t pix_y;
    logic     pix_valid;
    logic     frame_end;
    logic     result_valid;
    logic     found;
    coord_x_t mean_x;
    coord_y_t mean_y;

    frame_capture #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_capture (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .arst_n      (arst_n),
        .D5M_D       (D5M_D),
        .D5M_FVAL    (D5M_FVAL),
        .D5M_LVAL    (D5M_LVAL),
        .pixel       (pixel),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .pix_valid   (pix_valid),
        .frame_end   (frame_end)
    );

    centroid_accum #(
        .THRESHOLD (THRESHOLD),
        .IMG_W     (IMG_W),
        .IMG_H     (IMG_H)
    ) u_centroid (
        .D5M_PIXLCLK  (D5M_PIXLCLK),
        .arst_n       (arst_n),
        .pixel        (pixel),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .pix_valid    (pix_valid),
        .frame_end    (frame_end),
        .result_valid (result_valid),
        .found        (found),
        .mean_x       (mean_x),
        .mean_y       (mean_y)
    );

    aim_control #(
        .LOCK_FRAMES (LOCK_FRAMES),
        .LOST_FRAMES (LOST_FRAMES),
        .IMG_W       (IMG_W),
        .IMG_H       (IMG_H)
    ) u_aim (
        .D5M_PIXLCLK  (D5M_PIXLCLK),
        .arst_n       (arst_n),
        .result_valid (result_valid),
        .found        (found),
        .mean_x       (mean_x),
        .mean_y       (mean_y),
        .aim_x        (aim_x),
        .aim_y        (aim_y),
        .fire         (fire)
    );

    // ====================
    // Servos
    // ====================
    servo_pwm #(
        .COORD_W    ($bits(coord_x_t)),
        .PWM_PERIOD (PWM_PERIOD),
        .PULSE_MIN  (PULSE_MIN),
        .PULSE_STEP (PULSE_STEP)
    ) u_pan (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .arst_n      (arst_n),
        .coord       (aim_x),
        .pwm         (pan_pwm)
    );

    servo_pwm #(
        .COORD_W    ($bits(coord_y_t)),
        .PWM_PERIOD (PWM_PERIOD),
        .PULSE_MIN  (PULSE_MIN),
        .PULSE_STEP (PULSE_STEP)
    ) u_tilt (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .arst_n      (arst_n),
        .coord       (aim_y),
        .pwm         (tilt_pwm)
    );

endmodule

`default_nettype wire
